/* Bender.yml */
package:
  name: bw_overlay

sources:
  - files:
      - design/bw_overlay_pkg.sv
      - design/vga_timing.sv
      - design/luma_threshold.sv
      - design/mask_decimator.sv
      - design/mask_ram.sv
      - design/overlay_reader.sv
      - design/bw_overlay_top.sv
  - target: test
    files:
      - verif/frame_source.sv
      - verif/bw_overlay_tb.sv

/* design/bw_overlay_pkg.sv */
`default_nettype none

package bw_overlay_pkg;

  // vector widths
  localparam int hcount_w = 11;  // display and source column
  localparam int vcount_w = 10;  // display and source row
  localparam int pixel_w  = 16;  // rgb565
  localparam int luma_w   = 7;   // grayscale level
  localparam int addr_w   = 14;  // mask address, covers mask_depth
  localparam int color_w  = 4;   // one vga channel

  typedef logic [hcount_w-1:0] hcount_t;
  typedef logic [vcount_w-1:0] vcount_t;
  typedef logic [pixel_w-1:0]  rgb565_t;
  typedef logic [luma_w-1:0]   luma_t;
  typedef logic [addr_w-1:0]   mask_addr_t;
  typedef logic [color_w-1:0]  vga_color_t;

  // mask geometry
  // 240 x 320 source frame, one pixel kept in decim_factor per axis
  localparam int decim_factor = 3;
  localparam int mask_width   = 80;   // 240 / 3
  localparam int mask_height  = 106;  // 318 / 3, last two source rows dropped
  localparam int mask_depth   = mask_width * mask_height;  // 8480 entries

endpackage

`default_nettype wire

/* design/bw_overlay_top.sv */
`default_nettype none

module bw_overlay_top #(
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int v_active = 768,
  parameter int v_front  = 3,
  parameter int v_sync   = 6,
  parameter int v_back   = 29,
  parameter int win_x    = 600,  // mask window origin on screen
  parameter int win_y    = 250
) (
  input  wire                             clk_65mhz,
  input  wire                             reset,
  input  wire                             src_valid,
  input  wire bw_overlay_pkg::rgb565_t     src_pixel,
  input  wire bw_overlay_pkg::hcount_t     src_hcount,
  input  wire bw_overlay_pkg::vcount_t     src_vcount,
  input  wire bw_overlay_pkg::luma_t       thresh_level,
  input  wire                             freeze,  // holds the stored mask
  output wire bw_overlay_pkg::vga_color_t  vga_r,
  output wire bw_overlay_pkg::vga_color_t  vga_g,
  output wire bw_overlay_pkg::vga_color_t  vga_b,
  output wire                             vga_hs,
  output wire                             vga_vs
);

  // display scan
  bw_overlay_pkg::hcount_t hcount;
  bw_overlay_pkg::vcount_t vcount;
  logic blank;
  logic hsync;
  logic vsync;

  // source path
  logic th_valid;
  logic th_bit;
  bw_overlay_pkg::hcount_t th_hcount;
  bw_overlay_pkg::vcount_t th_vcount;
  logic wr_en;
  bw_overlay_pkg::mask_addr_t wr_addr;
  logic wr_bit;

  // readout
  bw_overlay_pkg::mask_addr_t rd_addr;
  logic rd_bit;

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) u_vga_timing (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .hcount    (hcount),
    .vcount    (vcount),
    .blank     (blank),
    .hsync     (hsync),
    .vsync     (vsync)
  );

  luma_threshold u_luma_threshold (
    .clk_65mhz    (clk_65mhz),
    .reset        (reset),
    .in_valid     (src_valid),
    .in_pixel     (src_pixel),
    .in_hcount    (src_hcount),
    .in_vcount    (src_vcount),
    .thresh_level (thresh_level),
    .out_valid    (th_valid),
    .out_bit      (th_bit),
    .out_hcount   (th_hcount),
    .out_vcount   (th_vcount)
  );

  mask_decimator u_mask_decimator (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .in_valid  (th_valid),
    .in_bit    (th_bit),
    .in_hcount (th_hcount),
    .in_vcount (th_vcount),
    .freeze    (freeze),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit)
  );

  mask_ram u_mask_ram (
    .clk_65mhz (clk_65mhz),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit),
    .rd_addr   (rd_addr),
    .rd_bit    (rd_bit)
  );

  overlay_reader #(
    .win_x (win_x),
    .win_y (win_y)
  ) u_overlay_reader (
    .clk_65mhz (clk_65mhz),
    .reset     (reset),
    .hcount    (hcount),
    .vcount    (vcount),
    .blank     (blank),
    .hsync     (hsync),
    .vsync     (vsync),
    .rd_addr   (rd_addr),
    .rd_bit    (rd_bit),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs)
  );

endmodule

`default_nettype wire

/* design/luma_threshold.sv */
`default_nettype none

module luma_threshold (
  input  wire                     clk_65mhz,
  input  wire                     reset,
  input  wire                     in_valid,
  input  wire bw_overlay_pkg::rgb565_t in_pixel,
  input  wire bw_overlay_pkg::hcount_t in_hcount,
  input  wire bw_overlay_pkg::vcount_t in_vcount,
  input  wire bw_overlay_pkg::luma_t   thresh_level,
  output logic                    out_valid,
  output logic                    out_bit,
  output bw_overlay_pkg::hcount_t out_hcount,
  output bw_overlay_pkg::vcount_t out_vcount
);

  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [8:0] luma_sum;  // wide enough to hold the full sum
  bw_overlay_pkg::luma_t level;

  // channels padded out to 8 bits
  assign red   = {in_pixel[15:11], 2'b00};
  assign green = {in_pixel[10:5], 1'b0};
  assign blue  = {in_pixel[4:0], 2'b00};

  // shift-and-add approximation of 0.3r + 0.59g + 0.11b
  assign luma_sum = 9'(red >> 2) + 9'(red >> 5) + 9'(red >> 6)
                  + 9'(green >> 1) + 9'(green >> 4) + 9'(green >> 5)
                  + 9'(blue >> 3) + 9'(blue >> 5);
  assign level = luma_sum[6:0];  // low bits only, bright pixels may wrap

  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload follows valid, no reset needed
  always_ff @(posedge clk_65mhz) begin
    out_bit    <= (level >= thresh_level);  // white when at or above threshold
    out_hcount <= in_hcount;
    out_vcount <= in_vcount;
  end

endmodule

`default_nettype wire

/* design/mask_decimator.sv */
`default_nettype none

module mask_decimator (
  input  wire                        clk_65mhz,
  input  wire                        reset,
  input  wire                        in_valid,
  input  wire                        in_bit,
  input  wire bw_overlay_pkg::hcount_t in_hcount,
  input  wire bw_overlay_pkg::vcount_t in_vcount,
  input  wire                        freeze,
  output logic                       wr_en,
  output bw_overlay_pkg::mask_addr_t wr_addr,
  output logic                       wr_bit
);

  localparam int coord_w = $clog2(bw_overlay_pkg::mask_height + 1);  // room for 106
  localparam logic [1:0] last_phase = 2'(bw_overlay_pkg::decim_factor - 1);

  logic [1:0]         col_phase_nxt;  // phase the next column will have
  logic [coord_w-1:0] mcol_nxt;
  logic [1:0]         row_phase;      // phase of the current row
  logic [coord_w-1:0] mrow;
  logic [1:0]         c_phase;        // this pixel
  logic [coord_w-1:0] c_mcol;
  logic [1:0]         r_phase;
  logic [coord_w-1:0] r_mrow;
  logic               freeze_d;       // freeze level that went in with this pixel

  always_comb begin
    if (in_hcount == '0) begin  // start of a row restarts the column phase
      c_phase = '0;
      c_mcol  = '0;
      if (in_vcount == '0) begin  // first row of a frame
        r_phase = '0;
        r_mrow  = '0;
      end else begin
        r_phase = (row_phase == last_phase) ? 2'd0 : row_phase + 2'd1;
        r_mrow  = (row_phase == last_phase) ? mrow + 1'b1 : mrow;
      end
    end else begin
      c_phase = col_phase_nxt;
      c_mcol  = mcol_nxt;
      r_phase = row_phase;
      r_mrow  = mrow;
    end
  end

  // phase state only moves on accepted pixels
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      col_phase_nxt <= '0;
      mcol_nxt      <= '0;
      row_phase     <= '0;
      mrow          <= '0;
      wr_en         <= 1'b0;
    end else begin
      if (in_valid) begin
        col_phase_nxt <= (c_phase == last_phase) ? 2'd0 : c_phase + 2'd1;
        mcol_nxt      <= (c_phase == last_phase) ? c_mcol + 1'b1 : c_mcol;
        row_phase     <= r_phase;
        mrow          <= r_mrow;
      end
      wr_en <= in_valid && (c_phase == '0) && (r_phase == '0) && !freeze_d &&
               (r_mrow < coord_w'(bw_overlay_pkg::mask_height));  // rows 318, 319 fall out
    end
  end

  always_ff @(posedge clk_65mhz) begin
    wr_addr  <= bw_overlay_pkg::mask_addr_t'(r_mrow * bw_overlay_pkg::mask_width + c_mcol);
    wr_bit   <= in_bit;
    freeze_d <= freeze;  // one cycle behind, same as the thresholded pixel
  end

endmodule

`default_nettype wire

/* design/mask_ram.sv */
`default_nettype none

module mask_ram (
  input  wire                            clk_65mhz,
  input  wire                            wr_en,
  input  wire bw_overlay_pkg::mask_addr_t wr_addr,
  input  wire                            wr_bit,
  input  wire bw_overlay_pkg::mask_addr_t rd_addr,
  output logic                           rd_bit
);

  // one bit per mask pixel, row major
  logic mem [0:bw_overlay_pkg::mask_depth-1];

  always_ff @(posedge clk_65mhz) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_bit;
    end
  end

  // read first, a colliding write shows up on the next read
  always_ff @(posedge clk_65mhz) begin
    rd_bit <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* design/overlay_reader.sv */
`default_nettype none

module overlay_reader #(
  parameter int win_x = 600,
  parameter int win_y = 250
) (
  input  wire                            clk_65mhz,
  input  wire                            reset,
  input  wire bw_overlay_pkg::hcount_t    hcount,
  input  wire bw_overlay_pkg::vcount_t    vcount,
  input  wire                            blank,
  input  wire                            hsync,
  input  wire                            vsync,
  output bw_overlay_pkg::mask_addr_t     rd_addr,
  input  wire                            rd_bit,
  output bw_overlay_pkg::vga_color_t     vga_r,
  output bw_overlay_pkg::vga_color_t     vga_g,
  output bw_overlay_pkg::vga_color_t     vga_b,
  output logic                           vga_hs,
  output logic                           vga_vs
);

  localparam int win_x_end = win_x + bw_overlay_pkg::mask_width;
  localparam int win_y_end = win_y + bw_overlay_pkg::mask_height;

  bw_overlay_pkg::mask_addr_t rd_cnt;  // address of the next window pixel
  logic in_win;
  logic at_origin;
  logic in_win_d1;  // lined up with rd_bit
  logic blank_d1;
  logic hsync_d1;
  logic vsync_d1;
  bw_overlay_pkg::vga_color_t pix;

  assign in_win = (hcount >= bw_overlay_pkg::hcount_t'(win_x)) &&
                  (hcount <  bw_overlay_pkg::hcount_t'(win_x_end)) &&
                  (vcount >= bw_overlay_pkg::vcount_t'(win_y)) &&
                  (vcount <  bw_overlay_pkg::vcount_t'(win_y_end));
  assign at_origin = (hcount == bw_overlay_pkg::hcount_t'(win_x)) &&
                     (vcount == bw_overlay_pkg::vcount_t'(win_y));

  // top-left corner restarts the scan at 0
  assign rd_addr = at_origin ? '0 : rd_cnt;

  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      rd_cnt <= '0;
    end else if (in_win) begin
      rd_cnt <= rd_addr + 1'b1;  // ascending, one per window pixel
    end
  end

  assign pix = (in_win_d1 && !blank_d1 && rd_bit) ? '1 : '0;  // white on black

  // stage 1 matches the ram latency, stage 2 is the output register
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      in_win_d1 <= 1'b0;
      blank_d1  <= 1'b1;
      hsync_d1  <= 1'b0;
      vsync_d1  <= 1'b0;
      vga_r     <= '0;
      vga_g     <= '0;
      vga_b     <= '0;
      vga_hs    <= 1'b1;  // idle high
      vga_vs    <= 1'b1;
    end else begin
      in_win_d1 <= in_win;
      blank_d1  <= blank;
      hsync_d1  <= hsync;
      vsync_d1  <= vsync;
      vga_r     <= pix;  // same level on all channels
      vga_g     <= pix;
      vga_b     <= pix;
      vga_hs    <= ~hsync_d1;  // active low on the pins
      vga_vs    <= ~vsync_d1;
    end
  end

endmodule

`default_nettype wire

/* design/vga_timing.sv */
`default_nettype none

module vga_timing #(
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int v_active = 768,
  parameter int v_front  = 3,
  parameter int v_sync   = 6,
  parameter int v_back   = 29
) (
  input  wire                     clk_65mhz,
  input  wire                     reset,
  output bw_overlay_pkg::hcount_t hcount,
  output bw_overlay_pkg::vcount_t vcount,
  output logic                    blank,
  output logic                    hsync,  // active high here, inverted at the output
  output logic                    vsync
);

  localparam int h_total      = h_active + h_front + h_sync + h_back;
  localparam int v_total      = v_active + v_front + v_sync + v_back;
  localparam int h_sync_start = h_active + h_front;  // pulse right after front porch
  localparam int v_sync_start = v_active + v_front;

  logic h_last;  // last column of the line
  logic v_last;  // last line of the frame

  assign h_last = (hcount == bw_overlay_pkg::hcount_t'(h_total - 1));
  assign v_last = (vcount == bw_overlay_pkg::vcount_t'(v_total - 1));

  // column counter, row advances on wrap
  always_ff @(posedge clk_65mhz) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      if (h_last) begin
        hcount <= '0;
        if (v_last) begin
          vcount <= '0;  // new frame
        end else begin
          vcount <= vcount + 1'b1;
        end
      end else begin
        hcount <= hcount + 1'b1;
      end
    end
  end

  // decoded straight from the counters
  always_comb begin
    blank = (hcount >= bw_overlay_pkg::hcount_t'(h_active)) ||
            (vcount >= bw_overlay_pkg::vcount_t'(v_active));
    hsync = (hcount >= bw_overlay_pkg::hcount_t'(h_sync_start)) &&
            (hcount <  bw_overlay_pkg::hcount_t'(h_sync_start + h_sync));
    vsync = (vcount >= bw_overlay_pkg::vcount_t'(v_sync_start)) &&
            (vcount <  bw_overlay_pkg::vcount_t'(v_sync_start + v_sync));
  end

endmodule

`default_nettype wire

/* flist.f */
design/bw_overlay_pkg.sv
design/vga_timing.sv
design/luma_threshold.sv
design/mask_decimator.sv
design/mask_ram.sv
design/overlay_reader.sv
design/bw_overlay_top.sv
verif/frame_source.sv
verif/bw_overlay_tb.sv

/* verif/bw_overlay_tb.sv */
`default_nettype none

module bw_overlay_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // small display, 200 x 130 cycles per frame
  localparam int h_active = 160;
  localparam int h_front  = 8;
  localparam int h_sync   = 16;
  localparam int h_back   = 16;
  localparam int v_active = 120;
  localparam int v_front  = 2;
  localparam int v_sync   = 3;
  localparam int v_back   = 5;
  localparam int win_x    = 40;
  localparam int win_y    = 8;
  localparam int h_total  = h_active + h_front + h_sync + h_back;
  localparam int v_total  = v_active + v_front + v_sync + v_back;
  localparam int src_w    = 240;
  localparam int src_h    = 320;
  localparam int src_frame_cycles  = src_w * src_h * 5 / 4;  // room for idle gaps
  localparam int disp_frame_cycles = h_total * v_total;
  localparam int timeout_cycles    = 5 * src_frame_cycles + 4 * disp_frame_cycles + 20000;

  logic clk_65mhz = 1'b0;
  logic reset;
  logic src_valid;
  bw_overlay_pkg::rgb565_t src_pixel;
  bw_overlay_pkg::hcount_t src_hcount;
  bw_overlay_pkg::vcount_t src_vcount;
  bw_overlay_pkg::luma_t   thresh_level;
  logic freeze;
  bw_overlay_pkg::vga_color_t vga_r;
  bw_overlay_pkg::vga_color_t vga_g;
  bw_overlay_pkg::vga_color_t vga_b;
  logic vga_hs;
  logic vga_vs;

  logic model [0:bw_overlay_pkg::mask_depth-1];  // expected mask contents
  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int cycle_cnt;
  // display position rebuilt from the sync outputs
  logic mon_on;
  logic pixel_check_on;
  logic prev_hs;
  logic prev_vs;
  logic hs_seen;
  logic vs_seen;
  int since_hs;  // cycles since vga_hs went high
  int hs_low;
  int lines_since_vs;  // hs rises since vga_vs went high
  int lines_vs_low;
  int frames_seen;

  always #2 clk_65mhz = ~clk_65mhz;

  frame_source #(.frame_w(src_w), .frame_h(src_h)) u_frame_source (
    .clk_65mhz    (clk_65mhz),
    .src_valid    (src_valid),
    .src_pixel    (src_pixel),
    .src_hcount   (src_hcount),
    .src_vcount   (src_vcount),
    .thresh_level (thresh_level),
    .freeze       (freeze)
  );

  bw_overlay_top #(
    .h_active (h_active), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
    .v_active (v_active), .v_front (v_front), .v_sync (v_sync), .v_back (v_back),
    .win_x    (win_x),    .win_y   (win_y)
  ) u_bw_overlay_top (
    .clk_65mhz    (clk_65mhz),
    .reset        (reset),
    .src_valid    (src_valid),
    .src_pixel    (src_pixel),
    .src_hcount   (src_hcount),
    .src_vcount   (src_vcount),
    .thresh_level (thresh_level),
    .freeze       (freeze),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .vga_hs       (vga_hs),
    .vga_vs       (vga_vs)
  );

  // grayscale level of one rgb565 pixel, low 7 bits
  function automatic int luma_of(input bw_overlay_pkg::rgb565_t p);
    int r8;
    int g8;
    int b8;
    int sum;
    r8  = int'(p[15:11]) * 4;
    g8  = int'(p[10:5]) * 2;
    b8  = int'(p[4:0]) * 4;
    sum = r8 / 4 + r8 / 32 + r8 / 64 + g8 / 2 + g8 / 16 + g8 / 32 + b8 / 8 + b8 / 32;
    return sum % 128;
  endfunction

  // colour expected at active pixel x, y
  function automatic bw_overlay_pkg::vga_color_t expected_color(input int x, input int y);
    int mx;
    int my;
    mx = x - win_x;
    my = y - win_y;
    if (x < 0 || x >= h_active || y < 0 || y >= v_active) return '0;  // blanking
    if (mx < 0 || mx >= bw_overlay_pkg::mask_width) return '0;
    if (my < 0 || my >= bw_overlay_pkg::mask_height) return '0;
    return model[my * bw_overlay_pkg::mask_width + mx] ? 4'hf : 4'h0;
  endfunction

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    $display("Fail %s: expected %h, got %h at %0t ns", name, expected, actual, $time);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  // one whole display frame compared against the model
  task automatic check_display_frame();
    int f0;
    repeat (4) @(posedge clk_65mhz);  // last writes land
    f0 = frames_seen;
    wait (frames_seen == f0 + 1);
    pixel_check_on = 1'b1;
    wait (frames_seen == f0 + 2);
    pixel_check_on = 1'b0;
  endtask

  // mask model, sampled where the dut samples the stream
  always @(posedge clk_65mhz) begin
    int col;
    int row;
    col = int'(src_hcount);
    row = int'(src_vcount);
    if (!reset && src_valid && !freeze && col % bw_overlay_pkg::decim_factor == 0 &&
        row % bw_overlay_pkg::decim_factor == 0 &&
        row / bw_overlay_pkg::decim_factor < bw_overlay_pkg::mask_height) begin
      model[(row / bw_overlay_pkg::decim_factor) * bw_overlay_pkg::mask_width +
            col / bw_overlay_pkg::decim_factor] = (luma_of(src_pixel) >= int'(thresh_level));
    end
  end

  // sync checks and pixel checks, sampled mid cycle
  always @(negedge clk_65mhz) begin
    bw_overlay_pkg::vga_color_t exp_c;
    if (mon_on) begin
      if (!prev_hs && vga_hs) begin  // end of an hs pulse
        checks++;
        assert (hs_low == h_sync) else report_value("vga_hs low cycles", h_sync, hs_low);
        if (hs_seen) begin
          checks++;
          assert (since_hs + 1 == h_total)
            else report_value("vga_hs period", h_total, since_hs + 1);
        end
        hs_seen  = 1'b1;
        hs_low   = 0;
        since_hs = 0;
        lines_since_vs++;
        if (!vga_vs) lines_vs_low++;
      end else begin
        since_hs++;
      end
      if (!vga_hs) hs_low++;
      if (!prev_vs && vga_vs) begin  // end of a vs pulse
        if (vs_seen) begin
          checks++;
          assert (lines_vs_low == v_sync)
            else report_value("vga_vs low lines", v_sync, lines_vs_low);
          assert (lines_since_vs == v_total)
            else report_value("vga_vs period lines", v_total, lines_since_vs);
        end
        vs_seen        = 1'b1;
        lines_since_vs = 0;
        lines_vs_low   = 0;
        frames_seen++;
      end
      if (pixel_check_on) begin
        exp_c = expected_color(since_hs - h_back, lines_since_vs - v_back);
        checks++;
        assert (vga_r === exp_c) else report_value("vga_r", exp_c, vga_r);
        assert (vga_g === exp_c) else report_value("vga_g", exp_c, vga_g);
        assert (vga_b === exp_c) else report_value("vga_b", exp_c, vga_b);
      end
      prev_hs = vga_hs;
      prev_vs = vga_vs;
    end
  end

  // run limit
  always @(posedge clk_65mhz) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int err_before;
    reset = 1'b1;
    {mon_on, pixel_check_on, hs_seen, vs_seen} = '0;
    prev_hs = 1'b1;  // idle level of the syncs
    prev_vs = 1'b1;
    {errors, checks, tests_run, tests_failed} = '0;
    {since_hs, hs_low, lines_since_vs, lines_vs_low, frames_seen} = '0;
    repeat (2) @(posedge clk_65mhz);
    #1;
    reset  = 1'b0;
    mon_on = 1'b1;

    err_before = errors;  // idle outputs, well before the first hs pulse
    repeat (150) begin
      @(negedge clk_65mhz);
      checks++;
      assert (vga_r === 4'h0) else report_value("vga_r", 0, vga_r);
      assert (vga_g === 4'h0) else report_value("vga_g", 0, vga_g);
      assert (vga_b === 4'h0) else report_value("vga_b", 0, vga_b);
      assert (vga_hs === 1'b1) else report_value("vga_hs", 1, vga_hs);
      assert (vga_vs === 1'b1) else report_value("vga_vs", 1, vga_vs);
    end
    finish_test("outputs after reset", err_before);

    err_before = errors;
    wait (frames_seen == 3);  // two full frames of sync checks
    finish_test("sync pulse widths", err_before);

    err_before = errors;
    u_frame_source.send_frame(7'h40, 1'b0);
    check_display_frame();
    finish_test("mask at mid threshold", err_before);

    err_before = errors;
    u_frame_source.send_frame(7'h40, 1'b1);  // new pixels, mask held
    check_display_frame();
    finish_test("freeze holds mask", err_before);

    err_before = errors;
    u_frame_source.send_frame(7'h00, 1'b0);  // every pixel passes
    check_display_frame();
    finish_test("zero threshold", err_before);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/frame_source.sv */
`default_nettype none

module frame_source #(
  parameter int frame_w = 240,
  parameter int frame_h = 320
) (
  input  wire                     clk_65mhz,
  output logic                    src_valid,
  output bw_overlay_pkg::rgb565_t src_pixel,
  output bw_overlay_pkg::hcount_t src_hcount,
  output bw_overlay_pkg::vcount_t src_vcount,
  output bw_overlay_pkg::luma_t   thresh_level,
  output logic                    freeze
);
  timeunit 1ns;
  timeprecision 1ps;

  integer seed;  // shared by pixel data and gap choice

  initial begin
    seed         = 32'h5880;
    src_valid    = 1'b0;
    src_pixel    = '0;
    src_hcount   = '0;
    src_vcount   = '0;
    thresh_level = '0;
    freeze       = 1'b0;
  end

  // one raster frame, levels held for the whole frame
  task automatic send_frame(input bw_overlay_pkg::luma_t level, input logic hold);
    int row;
    int col;
    @(posedge clk_65mhz);
    #1;
    thresh_level = level;
    freeze       = hold;
    for (row = 0; row < frame_h; row++) begin
      for (col = 0; col < frame_w; col++) begin
        while (($random(seed) & 7) == 0) begin  // about one cycle in eight idle
          src_valid = 1'b0;
          src_pixel = bw_overlay_pkg::rgb565_t'($random(seed));  // junk, must be ignored
          @(posedge clk_65mhz);
          #1;
        end
        src_valid  = 1'b1;
        src_pixel  = bw_overlay_pkg::rgb565_t'($random(seed));
        src_hcount = bw_overlay_pkg::hcount_t'(col);
        src_vcount = bw_overlay_pkg::vcount_t'(row);
        @(posedge clk_65mhz);
        #1;
      end
    end
    src_valid = 1'b0;  // stream idle between frames
  endtask

endmodule

`default_nettype wire
